// ==== verilog/mipsIsaPkg.sv ====
package mipsIsaPkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word
    //////////////////////////////////////////////////////////////////////

    // One 32-bit word with two field layouts
    typedef union packed {
        // Coprocessor 0 moves and eret
        struct packed {
            logic [5:0] op;
            logic [4:0] copOp;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [7:0] zero;
            logic [2:0] sel;
        } cop0;
        // Special opcode group, syscall lives here
        struct packed {
            logic [5:0]  op;
            logic [19:0] code;
            logic [5:0]  funct;
        } special;
    } instrWord;

    //////////////////////////////////////////////////////////////////////
    // Opcode fields
    //////////////////////////////////////////////////////////////////////

    // Major opcodes
    localparam logic [5:0] opCop0    = 6'b010000;
    localparam logic [5:0] opSpecial = 6'b000000;

    // Coprocessor sub-ops in the rs slot
    localparam logic [4:0] copMf = 5'b00000;
    localparam logic [4:0] copMt = 5'b00100;
    // CO bit set, function in the low bits
    localparam logic [4:0] copCo = 5'b10000;

    // Function codes
    localparam logic [5:0] functEret    = 6'b011000;
    localparam logic [5:0] functSyscall = 6'b001100;

    //////////////////////////////////////////////////////////////////////
    // Decoded class
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        classMfc0,
        classMtc0,
        classEret,
        classSyscall,
        // Anything not recognised above
        classReserved
    } instrClass;

endpackage

// ==== verilog/cp0Pkg.sv ====
package cp0Pkg;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [4:0] regStatus = 5'd12;
    localparam logic [4:0] regCause  = 5'd13;
    localparam logic [4:0] regEpc    = 5'd14;

    // Status bits
    localparam int statusIe   = 0;
    localparam int statusExl  = 1;
    // Interrupt mask field
    localparam int statusImHi = 15;
    localparam int statusImLo = 10;

    // Cause bits
    localparam int causeBd    = 31;
    // Pending interrupts, mirror of hwInt
    localparam int causeIpHi  = 15;
    localparam int causeIpLo  = 10;
    localparam int causeExcHi = 6;
    localparam int causeExcLo = 2;

    //////////////////////////////////////////////////////////////////////
    // Exception codes and result kinds
    //////////////////////////////////////////////////////////////////////

    localparam logic [4:0] excInt = 5'd0;
    localparam logic [4:0] excSys = 5'd8;
    localparam logic [4:0] excRi  = 5'd10;

    // What the core does with a finished instruction
    typedef enum logic [1:0] {
        kindDone,
        kindWrite,
        kindRedirect
    } resultKind;

endpackage

// ==== verilog/cp0Decode.sv ====
`timescale 1ns/1ps

module cp0Decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    output logic                  inReady,
    input  mipsIsaPkg::instrWord  inInstr,
    input  logic [31:0]           inPc,
    input  logic                  inDelaySlot,
    input  logic [31:0]           inRtValue,
    output logic                  decValid,
    input  logic                  decReady,
    output mipsIsaPkg::instrClass decClass,
    output logic [4:0]            decRd,
    output logic [4:0]            decRt,
    output logic [31:0]           decPc,
    output logic                  decDelaySlot,
    output logic [31:0]           decRtValue
);
    import mipsIsaPkg::*;

    logic [5:0] opcode;
    logic       cop0Clean;
    logic       eretMatch;
    logic       load;
    instrClass  nextClass;

    //////////////////////////////////////////////////////////////////////
    // Classification
    //////////////////////////////////////////////////////////////////////

    // Opcode sits at the same bits in both views
    assign opcode = inInstr.cop0.op;

    // Moves need the unused field and sel both zero
    assign cop0Clean = (inInstr.cop0.zero == 8'd0) && (inInstr.cop0.sel == 3'd0);

    // eret has rt, rd and the upper low bits clear
    assign eretMatch = ({inInstr.cop0.rt, inInstr.cop0.rd, inInstr.cop0.zero,
                         inInstr.cop0.sel} == {15'd0, functEret});

    always_comb begin
        nextClass = classReserved;
        case (opcode)
            opCop0: begin
                if (inInstr.cop0.copOp == copMf && cop0Clean) begin
                    nextClass = classMfc0;
                end else if (inInstr.cop0.copOp == copMt && cop0Clean) begin
                    nextClass = classMtc0;
                end else if (inInstr.cop0.copOp == copCo && eretMatch) begin
                    nextClass = classEret;
                end
            end
            opSpecial: begin
                // Code field is ignored
                if (inInstr.special.funct == functSyscall) begin
                    nextClass = classSyscall;
                end
            end
            default: nextClass = classReserved;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Stage slot
    //////////////////////////////////////////////////////////////////////

    // Take a new item when empty or when execute is taking ours
    assign inReady = !decValid || decReady;
    assign load    = inValid && inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (inReady) begin
            decValid <= inValid;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (load) begin
            decClass     <= nextClass;
            decRd        <= inInstr.cop0.rd;
            decRt        <= inInstr.cop0.rt;
            decPc        <= inPc;
            decDelaySlot <= inDelaySlot;
            decRtValue   <= inRtValue;
        end
    end

endmodule

// ==== verilog/cp0Execute.sv ====
`timescale 1ns/1ps

module cp0Execute #(
    parameter logic [31:0] handlerAddr = 32'h00004180
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [5:0]            hwInt,
    input  logic                  decValid,
    output logic                  decReady,
    input  mipsIsaPkg::instrClass decClass,
    input  logic [4:0]            decRd,
    input  logic [4:0]            decRt,
    input  logic [31:0]           decPc,
    input  logic                  decDelaySlot,
    input  logic [31:0]           decRtValue,
    output logic                  exeValid,
    input  logic                  exeReady,
    output cp0Pkg::resultKind     exeKind,
    output logic [4:0]            exeReg,
    output logic [31:0]           exeData
);
    import mipsIsaPkg::*;
    import cp0Pkg::*;

    // Coprocessor registers
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;

    logic        accept;
    logic        exl;
    logic        ie;
    logic        excTrap;
    logic        intTrap;
    logic        take;
    logic [4:0]  excCode;
    logic [31:0] readValue;
    resultKind   nextKind;
    logic [4:0]  nextReg;
    logic [31:0] nextData;

    //////////////////////////////////////////////////////////////////////
    // Trap detection
    //////////////////////////////////////////////////////////////////////

    assign exl = status[statusExl];
    assign ie  = status[statusIe];

    // Synchronous exceptions, blocked while EXL is set
    assign excTrap = !exl && (decClass == classSyscall || decClass == classReserved);

    // Interrupt only when no exception claims this item
    assign intTrap = !exl && ie && !excTrap &&
                     (|(hwInt & status[statusImHi:statusImLo]));

    assign take = excTrap || intTrap;

    always_comb begin
        if (excTrap) begin
            excCode = (decClass == classSyscall) ? excSys : excRi;
        end else begin
            excCode = excInt;
        end
    end

    // mfc0 source, unmapped numbers read zero
    always_comb begin
        case (decRd)
            regStatus: readValue = status;
            regCause:  readValue = cause;
            regEpc:    readValue = epc;
            default:   readValue = 32'd0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result forming
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextKind = kindDone;
        nextReg  = 5'd0;
        nextData = 32'd0;
        if (take) begin
            // Trap wins over whatever the instruction was
            nextKind = kindRedirect;
            nextData = handlerAddr;
        end else begin
            case (decClass)
                classMfc0: begin
                    nextKind = kindWrite;
                    nextReg  = decRt;
                    nextData = readValue;
                end
                classEret: begin
                    nextKind = kindRedirect;
                    nextData = epc;
                end
                // mtc0 and blocked traps just complete
                default: nextKind = kindDone;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register update
    //////////////////////////////////////////////////////////////////////

    assign decReady = !exeValid || exeReady;
    assign accept   = decValid && decReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= 32'd0;
            cause  <= 32'd0;
            epc    <= 32'd0;
        end else begin
            if (accept) begin
                if (take) begin
                    // Restart point is the branch when in a delay slot
                    epc                          <= decDelaySlot ? decPc - 32'd4 : decPc;
                    cause[causeBd]               <= decDelaySlot;
                    cause[causeExcHi:causeExcLo] <= excCode;
                    status[statusExl]            <= 1'b1;
                end else if (decClass == classMtc0) begin
                    case (decRd)
                        regStatus: status <= decRtValue;
                        regCause:  cause  <= decRtValue;
                        regEpc:    epc    <= decRtValue;
                        default:   ;
                    endcase
                end else if (decClass == classEret) begin
                    status[statusExl] <= 1'b0;
                end
            end
            // Pending bits track the lines, overriding any mtc0 write
            cause[causeIpHi:causeIpLo] <= hwInt;
        end
    end

    // Output slot
    always_ff @(posedge clk) begin
        if (reset) begin
            exeValid <= 1'b0;
        end else if (decReady) begin
            exeValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exeKind <= nextKind;
            exeReg  <= nextReg;
            exeData <= nextData;
        end
    end

endmodule

// ==== verilog/cp0Result.sv ====
`timescale 1ns/1ps

module cp0Result #(
    parameter int queueDepth = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              exeValid,
    output logic              exeReady,
    input  cp0Pkg::resultKind exeKind,
    input  logic [4:0]        exeReg,
    input  logic [31:0]       exeData,
    output logic              outValid,
    input  logic              outReady,
    output cp0Pkg::resultKind outKind,
    output logic [4:0]        outReg,
    output logic [31:0]       outData
);
    import cp0Pkg::*;

    localparam int ptrW = $clog2(queueDepth);
    localparam int cntW = $clog2(queueDepth + 1);
    localparam logic [ptrW-1:0] lastIdx   = ptrW'(queueDepth - 1);
    localparam logic [cntW-1:0] fullCount = cntW'(queueDepth);

    // Storage
    resultKind   kindMem [0:queueDepth-1];
    logic [4:0]  regMem  [0:queueDepth-1];
    logic [31:0] dataMem [0:queueDepth-1];

    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            fresh;
    logic            push;
    logic            pop;

    //////////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////////

    assign exeReady = (count != fullCount);
    assign push     = exeValid && exeReady;
    assign pop      = outValid && outReady;

    // Newest entry stays hidden for the cycle after its write
    assign outValid = (count > {{(cntW - 1){1'b0}}, fresh});

    // Head of the queue
    assign outKind = kindMem[rdPtr];
    assign outReg  = regMem[rdPtr];
    assign outData = dataMem[rdPtr];

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            fresh <= 1'b0;
        end else begin
            fresh <= push;
            if (push) begin
                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            kindMem[wrPtr] <= exeKind;
            regMem[wrPtr]  <= exeReg;
            dataMem[wrPtr] <= exeData;
        end
    end

endmodule

// ==== verilog/cp0Subsystem.sv ====
`timescale 1ns/1ps

module cp0Subsystem #(
    parameter logic [31:0] handlerAddr = 32'h00004180,
    parameter int          queueDepth  = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [5:0]           hwInt,
    input  logic                 inValid,
    output logic                 inReady,
    input  mipsIsaPkg::instrWord inInstr,
    input  logic [31:0]          inPc,
    input  logic                 inDelaySlot,
    input  logic [31:0]          inRtValue,
    output logic                 outValid,
    input  logic                 outReady,
    output cp0Pkg::resultKind    outKind,
    output logic [4:0]           outReg,
    output logic [31:0]          outData
);
    import mipsIsaPkg::*;
    import cp0Pkg::*;

    // Decode to execute
    logic        decValid;
    logic        decReady;
    instrClass   decClass;
    logic [4:0]  decRd;
    logic [4:0]  decRt;
    logic [31:0] decPc;
    logic        decDelaySlot;
    logic [31:0] decRtValue;

    // Execute to result queue
    logic        exeValid;
    logic        exeReady;
    resultKind   exeKind;
    logic [4:0]  exeReg;
    logic [31:0] exeData;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////

    cp0Decode decodeStage (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .inReady      (inReady),
        .inInstr      (inInstr),
        .inPc         (inPc),
        .inDelaySlot  (inDelaySlot),
        .inRtValue    (inRtValue),
        .decValid     (decValid),
        .decReady     (decReady),
        .decClass     (decClass),
        .decRd        (decRd),
        .decRt        (decRt),
        .decPc        (decPc),
        .decDelaySlot (decDelaySlot),
        .decRtValue   (decRtValue)
    );

    // Holds Status, Cause and EPC
    cp0Execute #(
        .handlerAddr (handlerAddr)
    ) executeStage (
        .clk          (clk),
        .reset        (reset),
        .hwInt        (hwInt),
        .decValid     (decValid),
        .decReady     (decReady),
        .decClass     (decClass),
        .decRd        (decRd),
        .decRt        (decRt),
        .decPc        (decPc),
        .decDelaySlot (decDelaySlot),
        .decRtValue   (decRtValue),
        .exeValid     (exeValid),
        .exeReady     (exeReady),
        .exeKind      (exeKind),
        .exeReg       (exeReg),
        .exeData      (exeData)
    );

    // Absorbs stalls on the output side
    cp0Result #(
        .queueDepth (queueDepth)
    ) resultQueue (
        .clk      (clk),
        .reset    (reset),
        .exeValid (exeValid),
        .exeReady (exeReady),
        .exeKind  (exeKind),
        .exeReg   (exeReg),
        .exeData  (exeData),
        .outValid (outValid),
        .outReady (outReady),
        .outKind  (outKind),
        .outReg   (outReg),
        .outData  (outData)
    );

endmodule

// ==== tests/cp0Model.svh ====
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Expected output of one instruction
typedef struct packed {
    resultKind   kind;
    logic [4:0]  regNum;
    logic [31:0] data;
} expectedResult;

// Model copy of the coprocessor registers
logic [31:0] modelStatus;
logic [31:0] modelCause;
logic [31:0] modelEpc;

// Sort a word into its class
function automatic instrClass classify(input instrWord w);
    if (w.cop0.op == opCop0) begin
        // Moves need bits 10 to 0 clear
        if (w.cop0.copOp == copMf && w[10:0] == 11'd0) begin
            return classMfc0;
        end
        if (w.cop0.copOp == copMt && w[10:0] == 11'd0) begin
            return classMtc0;
        end
        if (w.cop0.copOp == copCo && w[20:0] == {15'd0, functEret}) begin
            return classEret;
        end
    end else if (w.special.op == opSpecial && w.special.funct == functSyscall) begin
        return classSyscall;
    end
    return classReserved;
endfunction

// mfc0 view of a register, pending bits are the live lines
function automatic logic [31:0] readReg(input logic [4:0] num, input logic [5:0] lines);
    logic [31:0] value;
    case (num)
        regStatus: value = modelStatus;
        regCause:  value = {modelCause[31:16], lines, modelCause[9:0]};
        regEpc:    value = modelEpc;
        default:   value = 32'd0;
    endcase
    return value;
endfunction

// Apply one instruction to the model and return its result
function automatic expectedResult refResult(input instrWord w, input logic [31:0] pc,
                                            input logic ds, input logic [31:0] rtv,
                                            input logic [5:0] lines);
    instrClass     cls;
    logic          trapExc;
    logic          trapInt;
    expectedResult res;
    cls     = classify(w);
    res     = '{kind: kindDone, regNum: 5'd0, data: 32'd0};
    // Traps only with EXL clear
    trapExc = !modelStatus[1] && (cls == classSyscall || cls == classReserved);
    trapInt = !modelStatus[1] && !trapExc && modelStatus[0] &&
              ((lines & modelStatus[15:10]) != 6'd0);
    if (trapExc || trapInt) begin
        // Back up to the branch for a delay slot
        modelEpc        = ds ? pc - 32'd4 : pc;
        modelCause[31]  = ds;
        modelCause[6:2] = trapInt ? excInt : ((cls == classSyscall) ? excSys : excRi);
        modelStatus[1]  = 1'b1;
        res.kind        = kindRedirect;
        res.data        = handlerAddr;
    end else begin
        case (cls)
            classMtc0: begin
                case (w.cop0.rd)
                    regStatus: modelStatus = rtv;
                    regCause:  modelCause  = rtv;
                    regEpc:    modelEpc    = rtv;
                    default:   ;
                endcase
            end
            classMfc0: begin
                res.kind   = kindWrite;
                res.regNum = w.cop0.rt;
                res.data   = readReg(w.cop0.rd, lines);
            end
            classEret: begin
                modelStatus[1] = 1'b0;
                res.kind       = kindRedirect;
                res.data       = modelEpc;
            end
            default: ;
        endcase
    end
    return res;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic checkKind(input resultKind got, input resultKind expected);
    if (got !== expected) begin
        $display("error outKind got %h expected %h", got, expected);
        errors++;
    end
endtask

// Register number only for writes, no data on a plain completion
task automatic checkData(input resultKind kind, input logic [4:0] gotReg,
                         input logic [4:0] expReg, input logic [31:0] gotData,
                         input logic [31:0] expData);
    if (kind == kindWrite && gotReg !== expReg) begin
        $display("error outReg got %h expected %h", gotReg, expReg);
        errors++;
    end
    if (kind != kindDone && gotData !== expData) begin
        $display("error outData got %h expected %h", gotData, expData);
        errors++;
    end
endtask

`endif

// ==== tests/cp0SubsystemTb.sv ====
`timescale 1ns/1ps

module cp0SubsystemTb;
    import mipsIsaPkg::*;
    import cp0Pkg::*;

    localparam logic [31:0] handlerAddr = 32'h00004180;
    localparam int          queueDepth  = 2;

    logic        clk;
    logic        reset;
    logic [5:0]  hwInt;
    logic        inValid;
    logic        inReady;
    instrWord    inInstr;
    logic [31:0] inPc;
    logic        inDelaySlot;
    logic [31:0] inRtValue;
    logic        outValid;
    logic        outReady;
    resultKind   outKind;
    logic [4:0]  outReg;
    logic [31:0] outData;

    // Bookkeeping
    integer        seed;
    int            errors = 0;
    int            checked = 0;
    int            issued = 0;
    int            cycles;
    int            readyMode;
    int            testErrors = 0;
    int            testChecked = 0;
    logic [31:0]   curPc;

    `include "cp0Model.svh"

    expectedResult expQ[$];
    expectedResult head;

    cp0Subsystem #(
        .handlerAddr (handlerAddr),
        .queueDepth  (queueDepth)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .hwInt       (hwInt),
        .inValid     (inValid),
        .inReady     (inReady),
        .inInstr     (inInstr),
        .inPc        (inPc),
        .inDelaySlot (inDelaySlot),
        .inRtValue   (inRtValue),
        .outValid    (outValid),
        .outReady    (outReady),
        .outKind     (outKind),
        .outReg      (outReg),
        .outData     (outData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction words
    //////////////////////////////////////////////////////////////////////

    function automatic instrWord mfc0Word(input logic [4:0] rt, input logic [4:0] rd);
        return {opCop0, copMf, rt, rd, 11'd0};
    endfunction

    function automatic instrWord mtc0Word(input logic [4:0] rt, input logic [4:0] rd);
        return {opCop0, copMt, rt, rd, 11'd0};
    endfunction

    function automatic instrWord eretWord();
        return {opCop0, copCo, 15'd0, functEret};
    endfunction

    function automatic instrWord syscallWord(input logic [19:0] code);
        return {opSpecial, code, functSyscall};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Driving tasks
    //////////////////////////////////////////////////////////////////////

    // Present one item and wait until the DUT takes it
    task automatic issue(input instrWord word, input logic ds, input logic [31:0] rtv);
        @(posedge clk);
        inValid     <= 1'b1;
        inInstr     <= word;
        inPc        <= curPc;
        inDelaySlot <= ds;
        inRtValue   <= rtv;
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        // Transfer happens at the coming edge
        expQ.push_back(refResult(word, curPc, ds, rtv, hwInt));
        issued++;
        curPc = curPc + 32'd4;
    endtask

    // Stop issuing and wait for every result
    task automatic drain();
        @(posedge clk);
        inValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Lines move only with the pipeline empty
    task automatic setLines(input logic [5:0] lines);
        @(posedge clk);
        hwInt <= lines;
        repeat (2) @(negedge clk);
    endtask

    task automatic issueRandom();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        instrWord    word;
        r  = $random(seed);
        v  = $random(seed);
        // Mostly mapped registers
        rd = (r[9:8] == 2'd3) ? r[14:10] : 5'd12 + {3'd0, r[9:8]};
        case (r[2:0])
            3'd0, 3'd1: word = mfc0Word(r[19:15], rd);
            3'd2, 3'd3: word = mtc0Word(r[19:15], rd);
            3'd4:       word = syscallWord(v[25:6]);
            3'd5:       word = eretWord();
            // Load opcode, not handled here
            3'd6:       word = {6'b100011, v[25:0]};
            // Nonzero sel
            default:    word = {opCop0, copMf, r[19:15], rd, 8'd0, 3'd1};
        endcase
        issue(word, r[30], v);
    endtask

    task automatic finishTest(input string name);
        drain();
        $display("%s: %0d results, %0d errors", name, checked - testChecked,
                 errors - testErrors);
        testChecked = checked;
        testErrors  = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    // Back-pressure pattern per phase
    always @(posedge clk) begin
        case (readyMode)
            1:       outReady <= ($random(seed) & 1) != 0;
            2:       outReady <= ($random(seed) & 3) == 0;
            default: outReady <= 1'b1;
        endcase
    end

    // Compare each result mid-cycle, before its transfer edge
    always @(negedge clk) begin
        if (!reset && outValid && outReady) begin
            if (expQ.size() == 0) begin
                $display("a result arrived with no instruction outstanding");
                errors++;
            end else begin
                head = expQ.pop_front();
                checkKind(outKind, head.kind);
                checkData(head.kind, outReg, head.regNum, outData, head.data);
                checked++;
            end
        end
    end

    // Limit grows with the number of issued instructions
    initial begin
        cycles = 0;
        while (cycles <= 40 * issued + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("results stopped arriving, %0d still outstanding", expQ.size());
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset       = 1'b1;
        hwInt       = 6'd0;
        inValid     = 1'b0;
        inInstr     = '0;
        inPc        = 32'd0;
        inDelaySlot = 1'b0;
        inRtValue   = 32'd0;
        outReady    = 1'b1;
        seed        = 81;
        readyMode   = 0;
        curPc       = 32'h00400000;
        modelStatus = 32'd0;
        modelCause  = 32'd0;
        modelEpc    = 32'd0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Writes then reads, IE clear so the lines stay quiet
        setLines(6'b101001);
        issue(mtc0Word(5'd8, regStatus), 1'b0, 32'h0000fc00);
        issue(mtc0Word(5'd8, regCause), 1'b0, 32'h80000224);
        issue(mtc0Word(5'd8, regEpc), 1'b0, 32'h12345678);
        issue(mfc0Word(5'd2, regStatus), 1'b0, 32'd0);
        issue(mfc0Word(5'd3, regCause), 1'b0, 32'd0);
        issue(mfc0Word(5'd4, regEpc), 1'b0, 32'd0);
        issue(mfc0Word(5'd5, 5'd9), 1'b0, 32'd0);
        finishTest("register readback");

        // Syscall, then a reserved word in a delay slot
        setLines(6'b000000);
        issue(mtc0Word(5'd8, regStatus), 1'b0, 32'd0);
        issue(syscallWord(20'h00123), 1'b0, 32'd0);
        issue(mfc0Word(5'd9, regEpc), 1'b0, 32'd0);
        issue(mfc0Word(5'd10, regCause), 1'b0, 32'd0);
        issue(eretWord(), 1'b0, 32'd0);
        issue(32'h8c430010, 1'b1, 32'd0);
        issue(mfc0Word(5'd9, regEpc), 1'b0, 32'd0);
        issue(mfc0Word(5'd10, regCause), 1'b0, 32'd0);
        issue(eretWord(), 1'b0, 32'd0);
        finishTest("syscall and reserved");

        // Second syscall inside the handler is ignored
        issue(syscallWord(20'd0), 1'b0, 32'd0);
        issue(mfc0Word(5'd9, regEpc), 1'b0, 32'd0);
        issue(syscallWord(20'd0), 1'b1, 32'd0);
        issue(mfc0Word(5'd9, regEpc), 1'b0, 32'd0);
        issue(eretWord(), 1'b0, 32'd0);
        issue(mfc0Word(5'd7, regStatus), 1'b0, 32'd0);
        finishTest("syscall with EXL set");

        // IE plus mask on lines 0 and 1
        issue(mtc0Word(5'd8, regStatus), 1'b0, 32'h00000c01);
        drain();
        // Line outside the mask
        setLines(6'b100000);
        issue(mfc0Word(5'd6, regStatus), 1'b0, 32'd0);
        drain();
        setLines(6'b000010);
        issue(mfc0Word(5'd11, regEpc), 1'b0, 32'd0);
        issue(mfc0Word(5'd12, regCause), 1'b0, 32'd0);
        // Mask off, EXL still set
        issue(mtc0Word(5'd8, regStatus), 1'b0, 32'h00000003);
        issue(eretWord(), 1'b0, 32'd0);
        issue(mfc0Word(5'd12, regStatus), 1'b0, 32'd0);
        finishTest("hardware interrupt");

        // Random mix across back-pressure phases
        setLines(6'b010100);
        for (int i = 0; i < 240; i++) begin
            if (i % 60 == 0) begin
                readyMode = ((i / 60) + 1) % 3;
            end
            issueRandom();
        end
        finishTest("random mix");
        readyMode = 0;
        repeat (10) @(negedge clk);

        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
verilog/mipsIsaPkg.sv
verilog/cp0Pkg.sv
verilog/cp0Decode.sv
verilog/cp0Execute.sv
verilog/cp0Result.sv
verilog/cp0Subsystem.sv
tests/cp0SubsystemTb.sv

// ==== Makefile ====
TOP = cp0SubsystemTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
